/* pp_defs.svh */
// ping-pong bridge sizing macros shared by packages and RTL
`ifndef PP_DEFS_SVH
`define PP_DEFS_SVH

// width of one data word on both FIFO and stream sides
`define PP_DATA_WIDTH 32

// words per ping-pong bank
`define PP_DEPTH 8

// width of size and count fields
// matches the 24 bit size ports of the FIFO read side
`define PP_SIZE_WIDTH 24

`endif

/* ppfifo_pkg.sv */
// ping-pong FIFO types for bank selection and size fields
package ppfifo_pkg;

  `include "pp_defs.svh"

  // one bit per bank
  // bit 0 is bank 0, bit 1 is bank 1
  // used for write ready and write active
  typedef logic [1:0] bank_sel_t;

  // bank fill count, bank read size, or frame size
  // also the word count kept per bank
  typedef logic [`PP_SIZE_WIDTH-1:0] size_t;

endpackage

/* axis_pkg.sv */
// stream side types for data and byte enables
package axis_pkg;

  `include "pp_defs.svh"

  // one data word, same on FIFO and stream side
  typedef logic [`PP_DATA_WIDTH-1:0] data_t;

  // one enable bit per data byte
  typedef logic [`PP_DATA_WIDTH/8-1:0] keep_t;

endpackage

/* ingress_loader.sv */
// four-phase req/ack receiver that fills a granted ping-pong bank
module ingress_loader (
  input  logic                  clk,
  input  logic                  rst,
  // four-phase ingress
  input  logic                  i_req,
  input  axis_pkg::data_t       i_data,
  input  logic                  i_eob,
  output logic                  o_ack,
  // FIFO write side
  input  ppfifo_pkg::bank_sel_t i_wr_rdy,
  input  ppfifo_pkg::size_t     i_wr_size,
  output ppfifo_pkg::bank_sel_t o_wr_act,
  output logic                  o_wr_stb,
  output axis_pkg::data_t       o_wr_data
);

  import ppfifo_pkg::*;

  // claim a bank, wait for req, hold ack until req drops
  typedef enum logic [1:0] {
    S_CLAIM,
    S_HOLD,
    S_ACK
  } state_t;

  state_t r_state;
  size_t  r_count;
  logic   last_word;

  // write straight through while a bank is held and req is up
  assign o_wr_stb  = (r_state == S_HOLD) && i_req;
  assign o_wr_data = i_data;

  // bank closes on a full count or an end-of-block word
  assign last_word = (size_t'(r_count + 1'b1) == i_wr_size) || i_eob;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state  <= S_CLAIM;
      r_count  <= '0;
      o_ack    <= 1'b0;
      o_wr_act <= '0;
    end else begin
      case (r_state)
        S_CLAIM: begin
          // bank 0 first when both are free
          r_count <= '0;
          if (i_wr_rdy[0]) begin
            o_wr_act <= 2'b01;
            r_state  <= S_HOLD;
          end else if (i_wr_rdy[1]) begin
            o_wr_act <= 2'b10;
            r_state  <= S_HOLD;
          end
        end
        S_HOLD: begin
          if (i_req) begin
            r_count <= r_count + 1'b1;
            o_ack   <= 1'b1;
            r_state <= S_ACK;
            // release in the cycle after the last write
            if (last_word) begin
              o_wr_act <= '0;
            end
          end
        end
        S_ACK: begin
          // source drops req, ack follows one cycle later
          if (!i_req) begin
            o_ack   <= 1'b0;
            r_state <= (o_wr_act != '0) ? S_HOLD : S_CLAIM;
          end
        end
        default: begin
          r_state <= S_CLAIM;
        end
      endcase
    end
  end

  // only one bank may be held at a time
  // and the FIFO no longer offers a held bank
  a_one_bank: assert property (@(posedge clk) disable iff (rst)
    $onehot0(o_wr_act) && ((o_wr_act & i_wr_rdy) == '0));

  // ack only answers a pending request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(o_ack) |-> i_req);

endmodule

/* ppfifo.sv */
// two-bank ping-pong buffer, write grant and in-order read presentation
`include "pp_defs.svh"

module ppfifo (
  input  logic                  clk,
  input  logic                  rst,
  // write side
  input  ppfifo_pkg::bank_sel_t i_wr_act,
  input  logic                  i_wr_stb,
  input  axis_pkg::data_t       i_wr_data,
  output ppfifo_pkg::bank_sel_t o_wr_rdy,
  output ppfifo_pkg::size_t     o_wr_size,
  // read side
  input  logic                  i_rd_act,
  input  logic                  i_rd_stb,
  output logic                  o_rd_rdy,
  output ppfifo_pkg::size_t     o_rd_size,
  output axis_pkg::data_t       o_rd_data
);

  import ppfifo_pkg::*;
  import axis_pkg::*;

  localparam int ptr_w = $clog2(`PP_DEPTH);

  // bank storage
  data_t     r_mem [2][`PP_DEPTH];
  // words written per bank
  size_t     r_fill [2];
  // bank finished, waiting or being read
  bank_sel_t r_done;
  // bank that finished first, next to be read
  logic      r_head;
  // previous act levels for release and return edges
  bank_sel_t r_wr_act_q;
  logic      r_rd_act_q;
  size_t     r_rd_ptr;

  logic      wr_bank;
  bank_sel_t wr_fin;
  logic      rd_ret;

  // loader holds at most one bank, so bit 1 names it
  assign wr_bank = i_wr_act[1];
  assign wr_fin  = r_wr_act_q & ~i_wr_act;
  assign rd_ret  = r_rd_act_q && !i_rd_act;

  // empty, unheld banks are offered to the loader
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      o_wr_rdy[b] = !r_done[b] && !i_wr_act[b] && (r_fill[b] == '0);
    end
  end
  assign o_wr_size = size_t'(`PP_DEPTH);

  // hidden while a bank is taken or just returned
  assign o_rd_rdy  = r_done[r_head] && !i_rd_act && !r_rd_act_q;
  assign o_rd_size = r_fill[r_head];
  // show-ahead read of the current word
  assign o_rd_data = r_mem[r_head][r_rd_ptr[ptr_w-1:0]];

  always_ff @(posedge clk) begin
    if (i_wr_stb) begin
      r_mem[wr_bank][r_fill[wr_bank][ptr_w-1:0]] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_fill     <= '{default: '0};
      r_done     <= '0;
      r_head     <= 1'b0;
      r_wr_act_q <= '0;
      r_rd_act_q <= 1'b0;
      r_rd_ptr   <= '0;
    end else begin
      r_wr_act_q <= i_wr_act;
      r_rd_act_q <= i_rd_act;
      if (i_wr_stb) begin
        r_fill[wr_bank] <= r_fill[wr_bank] + 1'b1;
      end
      // a release becomes the head if the other bank is not queued
      for (int b = 0; b < 2; b++) begin
        if (wr_fin[b]) begin
          r_done[b] <= 1'b1;
          if (!r_done[1-b]) begin
            r_head <= 1'(b);
          end
        end
      end
      // returned bank is empty again, other bank is next
      if (rd_ret) begin
        r_done[r_head] <= 1'b0;
        r_fill[r_head] <= '0;
        r_head         <= ~r_head;
      end
      if (!i_rd_act) begin
        r_rd_ptr <= '0;
      end else if (i_rd_stb) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
    end
  end

  a_wr_stb_act: assert property (@(posedge clk) disable iff (rst)
    i_wr_stb |-> (i_wr_act != '0));

  a_rd_in_range: assert property (@(posedge clk) disable iff (rst)
    i_rd_stb |-> (i_rd_act && (r_rd_ptr < o_rd_size)));

endmodule

/* ppfifo_to_axis.sv */
// drains finished ping-pong banks onto an AXI-Stream with frame tlast
module ppfifo_to_axis (
  input  logic              clk,
  input  logic              rst,
  // FIFO read side
  input  logic              i_rd_rdy,
  input  ppfifo_pkg::size_t i_rd_size,
  input  axis_pkg::data_t   i_rd_data,
  output logic              o_rd_act,
  output logic              o_rd_stb,
  // stream side
  input  ppfifo_pkg::size_t i_total_size,
  input  logic              i_axis_ready,
  output axis_pkg::data_t   o_axis_data,
  output axis_pkg::keep_t   o_axis_keep,
  output logic              o_axis_last,
  output logic              o_axis_valid
);

  import ppfifo_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READY,
    S_RELEASE
  } state_t;

  state_t r_state;
  // beats taken from the current bank
  size_t  r_count;
  // beats sent in the current frame
  size_t  r_total_count;
  logic   xfer;

  assign xfer        = o_axis_valid && i_axis_ready;
  // each beat pops one word
  assign o_rd_stb    = xfer;
  assign o_axis_data = i_rd_data;
  assign o_axis_keep = '1;
  // frame may span several banks
  assign o_axis_last = o_axis_valid && (size_t'(r_total_count + 1'b1) == i_total_size);

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state       <= S_IDLE;
      r_count       <= '0;
      r_total_count <= '0;
      o_rd_act      <= 1'b0;
      o_axis_valid  <= 1'b0;
    end else begin
      case (r_state)
        S_IDLE: begin
          if (i_rd_rdy) begin
            r_count  <= '0;
            o_rd_act <= 1'b1;
            r_state  <= S_READY;
          end
        end
        S_READY: begin
          if (r_count < i_rd_size) begin
            if (xfer) begin
              r_count <= r_count + 1'b1;
              // drop valid after the bank's final beat
              if (size_t'(r_count + 1'b1) >= i_rd_size) begin
                o_axis_valid <= 1'b0;
              end
            end else begin
              o_axis_valid <= 1'b1;
            end
          end else begin
            // bank empty, hand it back
            o_rd_act <= 1'b0;
            r_state  <= S_RELEASE;
          end
        end
        S_RELEASE: begin
          r_state <= S_IDLE;
        end
        default: begin
          r_state <= S_IDLE;
        end
      endcase
      if (xfer) begin
        r_total_count <= o_axis_last ? '0 : r_total_count + 1'b1;
      end
    end
  end

  // stall holds the beat
  a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    (o_axis_valid && !i_axis_ready) |=> (o_axis_valid && $stable(o_axis_data)));

endmodule

/* stream_bridge_top.sv */
// req/ack to AXI-Stream bridge built around a ping-pong FIFO
module stream_bridge_top (
  input  logic              clk,
  input  logic              rst,
  // four-phase ingress
  input  logic              i_req,
  input  axis_pkg::data_t   i_data,
  input  logic              i_eob,
  output logic              o_ack,
  // stream egress
  input  ppfifo_pkg::size_t i_total_size,
  input  logic              i_axis_ready,
  output axis_pkg::data_t   o_axis_data,
  output axis_pkg::keep_t   o_axis_keep,
  output logic              o_axis_last,
  output logic              o_axis_valid
);

  import ppfifo_pkg::*;
  import axis_pkg::*;

  // loader to FIFO
  bank_sel_t wr_rdy;
  bank_sel_t wr_act;
  size_t     wr_size;
  logic      wr_stb;
  data_t     wr_data;
  // FIFO to adapter
  logic      rd_rdy;
  logic      rd_act;
  logic      rd_stb;
  size_t     rd_size;
  data_t     rd_data;

  ingress_loader u_loader (
    .clk       (clk),
    .rst       (rst),
    .i_req     (i_req),
    .i_data    (i_data),
    .i_eob     (i_eob),
    .o_ack     (o_ack),
    .i_wr_rdy  (wr_rdy),
    .i_wr_size (wr_size),
    .o_wr_act  (wr_act),
    .o_wr_stb  (wr_stb),
    .o_wr_data (wr_data)
  );

  ppfifo u_fifo (
    .clk       (clk),
    .rst       (rst),
    .i_wr_act  (wr_act),
    .i_wr_stb  (wr_stb),
    .i_wr_data (wr_data),
    .o_wr_rdy  (wr_rdy),
    .o_wr_size (wr_size),
    .i_rd_act  (rd_act),
    .i_rd_stb  (rd_stb),
    .o_rd_rdy  (rd_rdy),
    .o_rd_size (rd_size),
    .o_rd_data (rd_data)
  );

  ppfifo_to_axis u_adapter (
    .clk          (clk),
    .rst          (rst),
    .i_rd_rdy     (rd_rdy),
    .i_rd_size    (rd_size),
    .i_rd_data    (rd_data),
    .o_rd_act     (rd_act),
    .o_rd_stb     (rd_stb),
    .i_total_size (i_total_size),
    .i_axis_ready (i_axis_ready),
    .o_axis_data  (o_axis_data),
    .o_axis_keep  (o_axis_keep),
    .o_axis_last  (o_axis_last),
    .o_axis_valid (o_axis_valid)
  );

endmodule

/* tb_stream_bridge.sv */
// testbench for the req/ack to AXI-Stream ping-pong bridge
`include "pp_defs.svh"

module tb_stream_bridge;

  import ppfifo_pkg::*;
  import axis_pkg::*;

  // words pushed over all phases
  localparam int n_words     = 6 * 8 + 6 * 5 + 4 * 8 + 3 * 8;
  localparam int max_cycle   = 4 * n_words * 20 + 200;
  // longest wait for the stream to empty after a phase
  localparam int drain_limit = 4 * 20 * `PP_DEPTH;

  logic  clk;
  logic  rst;
  logic  i_req;
  data_t i_data;
  logic  i_eob;
  size_t i_total_size;
  logic  i_axis_ready;
  logic  o_ack;
  data_t o_axis_data;
  keep_t o_axis_keep;
  logic  o_axis_last;
  logic  o_axis_valid;

  // scoreboard, oldest unmatched word at the front
  data_t exp_q[$];
  // beats seen so far in the current frame
  int    beat_in_frame;
  // 0 ready high, 1 random, 2 held low
  int    ready_mode;
  logic  seen_req;
  logic  req_q;
  logic  ack_q;
  int    req_count;
  int    ack_count;
  int    ack_base;
  int    cycles;
  int    data_errors;
  int    last_errors;
  int    proto_errors;
  int    hs_errors;

  stream_bridge_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .i_req        (i_req),
    .i_data       (i_data),
    .i_eob        (i_eob),
    .o_ack        (o_ack),
    .i_total_size (i_total_size),
    .i_axis_ready (i_axis_ready),
    .o_axis_data  (o_axis_data),
    .o_axis_keep  (o_axis_keep),
    .o_axis_last  (o_axis_last),
    .o_axis_valid (o_axis_valid)
  );

  always #5 clk = ~clk;

  // stream ready pattern per phase
  always @(posedge clk) begin
    case (ready_mode)
      0: i_axis_ready <= 1'b1;
      1: i_axis_ready <= 1'($urandom % 2);
      default: i_axis_ready <= 1'b0;
    endcase
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycle) begin
      $display("timeout after %0d cycles, the bridge stopped moving words", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // quiet outputs until the first request
  a_quiet_start: assert property (@(posedge clk) disable iff (rst)
    !seen_req |-> (!o_ack && !o_axis_valid && !o_axis_last))
    else begin
      proto_errors++;
      $display("protocol error at %0t: output active before any request", $time);
    end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(o_ack) |-> i_req)
    else begin
      hs_errors++;
      $display("handshake error at %0t: ack rose without a request", $time);
    end

  // stalled beat must hold
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    (o_axis_valid && !i_axis_ready) |=> (o_axis_valid && $stable(o_axis_data)))
    else begin
      proto_errors++;
      $display("protocol error at %0t: beat dropped or changed under stall", $time);
    end

  a_keep_ones: assert property (@(posedge clk) disable iff (rst)
    o_axis_valid |-> (o_axis_keep == '1))
    else begin
      proto_errors++;
      $display("mismatch at %0t: keep %h, expected all ones", $time, o_axis_keep);
    end

  // sample at negedge, where everything driven at posedge has settled
  always @(negedge clk) begin
    logic exp_last;
    if (!rst) begin
      if (i_req) seen_req = 1'b1;
      if (i_req && !req_q) req_count++;
      if (o_ack && !ack_q) ack_count++;
      req_q = i_req;
      ack_q = o_ack;
      // valid and ready now means a transfer on the next edge
      if (o_axis_valid && i_axis_ready) begin
        // frame ends when its beat count reaches the frame size
        beat_in_frame++;
        exp_last = (beat_in_frame == int'(i_total_size));
        if (exp_q.size() == 0) begin
          data_errors++;
          $display("unexpected beat at %0t: no sent word is waiting", $time);
        end else begin
          a_data: assert (o_axis_data == exp_q[0]) else begin
            data_errors++;
            $display("mismatch at %0t: data %h, expected %h", $time, o_axis_data, exp_q[0]);
          end
          void'(exp_q.pop_front());
        end
        a_last: assert (o_axis_last == exp_last) else begin
          last_errors++;
          $display("mismatch at %0t: last %b, expected %b", $time, o_axis_last, exp_last);
        end
        if (exp_last) begin
          beat_in_frame = 0;
        end
      end
    end
  end

  // one full four-phase handshake
  task automatic send_word(input logic eob);
    data_t w;
    w = $urandom;
    @(posedge clk);
    i_req  <= 1'b1;
    i_data <= w;
    i_eob  <= eob;
    exp_q.push_back(w);
    do @(negedge clk); while (!o_ack);
    @(posedge clk);
    i_req <= 1'b0;
    do @(negedge clk); while (o_ack);
  endtask

  // eob on the last word of each frame
  task automatic send_frames(input int n_frames, input int frame_len);
    for (int f = 0; f < n_frames; f++) begin
      for (int k = 0; k < frame_len; k++) begin
        send_word(k == frame_len - 1);
      end
    end
  endtask

  // give up on leftover words after drain_limit cycles
  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < drain_limit)) begin
      @(negedge clk);
      n++;
    end
    repeat (4) @(negedge clk);
  endtask

  task automatic set_total(input int n);
    @(posedge clk);
    i_total_size <= size_t'(n);
    @(negedge clk);
  endtask

  initial begin
    void'($urandom(32'h8785_c413));
    clk = 1'b0;
    rst = 1'b1;
    i_req = 1'b0;
    i_data = '0;
    i_eob = 1'b0;
    i_total_size = size_t'(8);
    i_axis_ready = 1'b1;
    ready_mode = 0;
    beat_in_frame = 0;
    seen_req = 1'b0;
    req_q = 1'b0;
    ack_q = 1'b0;
    req_count = 0;
    ack_count = 0;
    ack_base = 0;
    cycles = 0;
    data_errors = 0;
    last_errors = 0;
    proto_errors = 0;
    hs_errors = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // idle spell before the first request
    repeat (10) @(negedge clk);
    // full banks, frame equals bank depth
    send_frames(6, 8);
    wait_drained();
    // partial banks closed by eob
    set_total(5);
    send_frames(6, 5);
    wait_drained();
    // random back-pressure
    set_total(8);
    ready_mode = 1;
    send_frames(4, 8);
    wait_drained();
    // stall long enough to fill both banks
    ready_mode = 2;
    ack_base = ack_count;
    fork
      send_frames(3, 8);
      begin
        repeat (150) @(negedge clk);
        a_stall_full: assert ((ack_count - ack_base == 2 * `PP_DEPTH) && i_req && !o_ack)
          else begin
            hs_errors++;
            $display("mismatch at %0t: %0d acks under stall, expected %0d",
              $time, ack_count - ack_base, 2 * `PP_DEPTH);
          end
        ready_mode = 0;
      end
    join
    wait_drained();
    if (exp_q.size() != 0) begin
      data_errors++;
      $display("%0d sent words never left the stream", exp_q.size());
    end
    if (req_count != ack_count) begin
      hs_errors++;
      $display("handshake error: %0d requests but %0d acks", req_count, ack_count);
    end
    $display("errors: data %0d, last %0d, protocol %0d, handshake %0d",
      data_errors, last_errors, proto_errors, hs_errors);
    if (data_errors + last_errors + proto_errors + hs_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+.
ppfifo_pkg.sv
axis_pkg.sv
ingress_loader.sv
ppfifo.sv
ppfifo_to_axis.sv
stream_bridge_top.sv
tb_stream_bridge.sv

/* run.sh */
#!/bin/sh
# build the bridge testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_stream_bridge \
  -f src.f -o sim_bridge \
  || { echo "build failed"; exit 1; }
./obj_dir/sim_bridge > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
